//--- common/sb_cfg_pkg.sv
// Scoreboard size configuration

package sb_cfg_pkg;

  // --------------------
  // Record and table sizes
  localparam int sb_width   = 8;   // Bits per record
  localparam int sb_items   = 64;  // Number of records
  localparam int sb_asz     = 6;   // Item address width
  localparam int sb_txid_sz = 2;   // Transaction id width

  // --------------------
  // Packed channel widths

  // Request is txid, opcode bit, item id, mask, data
  localparam int sb_req_sz = sb_txid_sz + 1 + sb_asz + sb_width + sb_width;

  // Response is txid and record
  localparam int sb_rsp_sz = sb_txid_sz + sb_width;

endpackage : sb_cfg_pkg

//--- common/sb_types_pkg.sv
// Scoreboard opcode and state types

package sb_types_pkg;

  // One-bit request opcode on the consumer port
  typedef enum logic {
    req_read  = 1'b0,
    req_write = 1'b1
  } sb_req_e;

  // Control FSM states
  typedef enum logic [1:0] {
    st_idle    = 2'd0,  // Waiting for a request
    st_read    = 2'd1,  // Memory read in flight
    st_merge   = 2'd2,  // Masked write back
    st_respond = 2'd3   // Read data offered to output hold
  } sb_state_e;

endpackage : sb_types_pkg

//--- scoreboard/sd_input.sv
// Scoreboard request input hold

`timescale 1ns/10ps

module sd_input
  import sb_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 c_srdy,
  output logic                 c_drdy,
  input  logic [sb_req_sz-1:0] c_data,
  output logic                 ip_srdy,
  input  logic                 ip_drdy,
  output logic [sb_req_sz-1:0] ip_data
);

  logic [sb_req_sz-1:0] hold_data [2];  // Payload entries
  logic                 empty;
  logic                 full;
  logic                 rd_sel;         // Entry at the head
  logic                 wr_slot;
  logic                 c_xfer;
  logic                 ip_xfer;

  assign c_xfer  = c_srdy & c_drdy;
  assign ip_xfer = ip_srdy & ip_drdy;

  // Empty hold writes to the head, otherwise to the other slot
  assign wr_slot = empty ? rd_sel : ~rd_sel;

  assign c_drdy  = ~full;    // Straight from a flop
  assign ip_srdy = ~empty;
  assign ip_data = hold_data[rd_sel];

  // --------------------
  // Occupancy flags and head pointer
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      empty  <= 1'b1;
      full   <= 1'b0;
      rd_sel <= 1'b0;
    end
    else
    begin
      case ({c_xfer, ip_xfer})
        2'b10:
        begin
          empty <= 1'b0;
          full  <= ~empty;  // Second entry taken
        end
        2'b01:
        begin
          full   <= 1'b0;
          empty  <= ~full;
          rd_sel <= ~rd_sel;
        end
        2'b11: rd_sel <= ~rd_sel;  // Count unchanged
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (c_xfer)
      hold_data[wr_slot] <= c_data;
  end

endmodule : sd_input

//--- scoreboard/sd_output.sv
// Scoreboard response output hold

`timescale 1ns/10ps

module sd_output
  import sb_cfg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ic_srdy,
  output logic                  ic_drdy,
  input  logic [sb_rsp_sz-1:0]  ic_data,
  output logic                  p_srdy,
  input  logic                  p_drdy,
  output logic [sb_txid_sz-1:0] p_txid,
  output logic [sb_width-1:0]   p_data
);

  logic [sb_rsp_sz-1:0] hold_data [2];
  logic                 empty;
  logic                 full;
  logic                 rd_sel;
  logic                 wr_slot;
  logic                 ic_xfer;
  logic                 p_xfer;

  assign ic_xfer = ic_srdy & ic_drdy;
  assign p_xfer  = p_srdy & p_drdy;
  assign wr_slot = empty ? rd_sel : ~rd_sel;

  assign ic_drdy = ~full;
  assign p_srdy  = ~empty;

  // Split head entry into id and record
  assign {p_txid, p_data} = hold_data[rd_sel];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      empty  <= 1'b1;
      full   <= 1'b0;
      rd_sel <= 1'b0;
    end
    else
    begin
      case ({ic_xfer, p_xfer})
        2'b10:
        begin
          empty <= 1'b0;
          full  <= ~empty;
        end
        2'b01:
        begin
          full   <= 1'b0;
          empty  <= ~full;
          rd_sel <= ~rd_sel;  // Advance to next response
        end
        2'b11: rd_sel <= ~rd_sel;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (ic_xfer)
      hold_data[wr_slot] <= ic_data;
  end

endmodule : sd_output

//--- scoreboard/behave1p_mem.sv
// Single-port record memory

`timescale 1ns/10ps

module behave1p_mem
  import sb_cfg_pkg::*;
(
  input  logic                clk,
  input  logic                rd_en,
  input  logic                wr_en,
  input  logic [sb_asz-1:0]   addr,
  input  logic [sb_width-1:0] d_in,
  output logic [sb_width-1:0] d_out
);

  logic [sb_width-1:0] mem [sb_items];  // One record per item

  // Registered read that holds its output when idle
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[addr] <= d_in;
    if (rd_en)
      d_out <= mem[addr];  // Old contents on a same-cycle write
  end

endmodule : behave1p_mem

//--- scoreboard/sd_scoreboard_fsm.sv
// Scoreboard control FSM

`timescale 1ns/10ps

module sd_scoreboard_fsm
  import sb_cfg_pkg::*;
  import sb_types_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ip_srdy,
  output logic                 ip_drdy,
  input  logic [sb_req_sz-1:0] ip_data,
  output logic                 ic_srdy,
  input  logic                 ic_drdy,
  output logic [sb_rsp_sz-1:0] ic_data,
  output logic                 rd_en,
  output logic                 wr_en,
  output logic [sb_asz-1:0]    addr,
  output logic [sb_width-1:0]  d_in,
  input  logic [sb_width-1:0]  d_out
);

  // --------------------
  // Request fields
  logic [sb_txid_sz-1:0] ip_txid;
  logic                  ip_req_bit;
  sb_req_e               ip_req;
  logic [sb_asz-1:0]     ip_itemid;
  logic [sb_width-1:0]   ip_mask;
  logic [sb_width-1:0]   ip_wdata;

  // Latched copy of the request in service
  logic [sb_txid_sz-1:0] txid_q;
  sb_req_e               req_q;
  logic [sb_asz-1:0]     item_q;
  logic [sb_width-1:0]   mask_q;
  logic [sb_width-1:0]   data_q;

  sb_state_e             state;
  sb_state_e             state_nxt;
  logic                  accept;

  assign {ip_txid, ip_req_bit, ip_itemid, ip_mask, ip_wdata} = ip_data;
  assign ip_req = sb_req_e'(ip_req_bit);

  assign accept = ip_srdy & ip_drdy;

  // Masked bits from the request, the rest from memory
  assign d_in = (data_q & mask_q) | (d_out & ~mask_q);

  assign ic_data = {txid_q, d_out};  // d_out stable until next read

  // --------------------
  // Next state and strobes
  always_comb
  begin
    state_nxt = state;
    ip_drdy   = 1'b0;
    ic_srdy   = 1'b0;
    rd_en     = 1'b0;
    wr_en     = 1'b0;
    addr      = item_q;
    case (state)
      st_idle:
      begin
        ip_drdy = 1'b1;
        addr    = ip_itemid;  // Read issued in the accept cycle
        if (ip_srdy)
        begin
          rd_en     = 1'b1;
          state_nxt = st_read;
        end
      end
      st_read:
      begin
        if (req_q == req_write)
          state_nxt = st_merge;
        else
          state_nxt = st_respond;
      end
      st_merge:
      begin
        wr_en     = 1'b1;
        state_nxt = st_idle;
      end
      st_respond:
      begin
        ic_srdy = 1'b1;
        if (ic_drdy)
          state_nxt = st_idle;  // Stalls here under back-pressure
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= st_idle;
    else
      state <= state_nxt;
  end

  // --------------------
  // Request capture
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      txid_q <= ip_txid;
      req_q  <= ip_req;
      item_q <= ip_itemid;
      mask_q <= ip_mask;
      data_q <= ip_wdata;
    end
  end

endmodule : sd_scoreboard_fsm

//--- scoreboard/sd_scoreboard.sv
// Scoreboard top level

`timescale 1ns/10ps

module sd_scoreboard
  import sb_cfg_pkg::*;
  import sb_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Consumer side
  input  logic                  c_srdy,
  output logic                  c_drdy,
  input  sb_req_e               c_req_type,
  input  logic [sb_txid_sz-1:0] c_txid,
  input  logic [sb_asz-1:0]     c_itemid,
  input  logic [sb_width-1:0]   c_mask,
  input  logic [sb_width-1:0]   c_data,

  // Producer side
  output logic                  p_srdy,
  input  logic                  p_drdy,
  output logic [sb_txid_sz-1:0] p_txid,
  output logic [sb_width-1:0]   p_data
);

  // --------------------
  // Internal channels
  logic [sb_req_sz-1:0] c_hold_data;  // Packed consumer request
  logic                 ip_srdy;
  logic                 ip_drdy;
  logic [sb_req_sz-1:0] ip_data;
  logic                 ic_srdy;
  logic                 ic_drdy;
  logic [sb_rsp_sz-1:0] ic_data;
  logic                 rd_en;
  logic                 wr_en;
  logic [sb_asz-1:0]    addr;
  logic [sb_width-1:0]  d_in;
  logic [sb_width-1:0]  d_out;

  // Field order shared with the FSM unpack
  assign c_hold_data = {c_txid, c_req_type, c_itemid, c_mask, c_data};

  sd_input inhold (
    .clk     (clk),
    .rst_n   (rst_n),
    .c_srdy  (c_srdy),
    .c_drdy  (c_drdy),
    .c_data  (c_hold_data),
    .ip_srdy (ip_srdy),
    .ip_drdy (ip_drdy),
    .ip_data (ip_data)
  );

  behave1p_mem sb_mem (
    .clk   (clk),
    .rd_en (rd_en),
    .wr_en (wr_en),
    .addr  (addr),
    .d_in  (d_in),
    .d_out (d_out)
  );

  sd_scoreboard_fsm fsm (
    .clk     (clk),
    .rst_n   (rst_n),
    .ip_srdy (ip_srdy),
    .ip_drdy (ip_drdy),
    .ip_data (ip_data),
    .ic_srdy (ic_srdy),
    .ic_drdy (ic_drdy),
    .ic_data (ic_data),
    .rd_en   (rd_en),
    .wr_en   (wr_en),
    .addr    (addr),
    .d_in    (d_in),
    .d_out   (d_out)
  );

  sd_output outhold (
    .clk     (clk),
    .rst_n   (rst_n),
    .ic_srdy (ic_srdy),
    .ic_drdy (ic_drdy),
    .ic_data (ic_data),
    .p_srdy  (p_srdy),
    .p_drdy  (p_drdy),
    .p_txid  (p_txid),
    .p_data  (p_data)
  );

endmodule : sd_scoreboard

//--- verif/tb_sd_scoreboard_tasks.svh
// Scoreboard directed tests

// Xorshift step on rng_state
function automatic logic [31:0] next_rand();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

task automatic report_test(input string name, input int err_start);
  tests_run++;
  if (errors == err_start)
    $display("%s: ok", name);
  else
  begin
    tests_failed++;
    $display("%s: %0d errors", name, errors - err_start);
  end
endtask

// --------------------
// Channel drivers called on a falling edge
task automatic send_req(input sb_req_e op, input logic [sb_txid_sz-1:0] id,
                        input logic [sb_asz-1:0] item, input logic [sb_width-1:0] mask,
                        input logic [sb_width-1:0] data);
  int waited;
  waited     = 0;
  c_srdy     = 1'b1;
  c_req_type = op;
  c_txid     = id;
  c_itemid   = item;
  c_mask     = mask;
  c_data     = data;
  while (!c_drdy && waited < max_wait)
  begin
    @(negedge clk);
    waited++;
  end
  if (!c_drdy)
  begin
    $display("Timeout at %0t: request to item %0d was never accepted", $time, item);
    errors++;
  end
  else if (op == req_write)
  begin
    model_mem[item]   = (model_mem[item] & ~mask) | (data & mask);  // Masked merge
    model_known[item] = 1'b1;
  end
  else
  begin
    exp_txid_q.push_back(id);
    exp_data_q.push_back(model_mem[item]);
  end
  @(negedge clk);  // Transfer on the edge in between
  c_srdy = 1'b0;
endtask

task automatic expect_rsp();
  int                    waited;
  logic [sb_txid_sz-1:0] etx;
  logic [sb_width-1:0]   edat;
  waited = 0;
  p_drdy = 1'b1;
  while (!p_srdy && waited < max_wait)
  begin
    @(negedge clk);
    waited++;
  end
  if (!p_srdy)
  begin
    $display("Timeout at %0t: no response arrived", $time);
    errors++;
  end
  else if (exp_txid_q.size() == 0)
  begin
    $display("Response at %0t arrived with none expected", $time);
    errors++;
  end
  else
  begin
    etx  = exp_txid_q.pop_front();
    edat = exp_data_q.pop_front();
    assert (p_txid == etx)
    else
    begin
      $display("ERROR at %0t: p_txid expected %0h, got %0h", $time, etx, p_txid);
      errors++;
    end
    assert (p_data == edat)
    else
    begin
      $display("ERROR at %0t: p_data expected %0h, got %0h", $time, edat, p_data);
      errors++;
    end
  end
  @(negedge clk);
  p_drdy = 1'b0;
endtask

// --------------------
// Directed tests
task automatic check_reset_outputs();
  int e0;
  e0 = errors;
  assert (p_srdy == 1'b0)
  else
  begin
    $display("ERROR at %0t: p_srdy expected 0, got %0b", $time, p_srdy);
    errors++;
  end
  assert (c_drdy == 1'b1)
  else
  begin
    $display("ERROR at %0t: c_drdy expected 1, got %0b", $time, c_drdy);
    errors++;
  end
  report_test("reset state", e0);
endtask

task automatic full_writes_readback();
  int          e0;
  logic [31:0] r;
  e0 = errors;
  for (int i = 0; i < 8; i++)
  begin
    r = next_rand();
    send_req(req_write, 2'd0, sb_asz'(i * 7), 8'hff, r[7:0]);
  end
  for (int i = 0; i < 8; i++)
  begin
    send_req(req_read, sb_txid_sz'(i), sb_asz'(i * 7), 8'h00, 8'h00);
    expect_rsp();
  end
  report_test("full mask writes", e0);
endtask

task automatic masked_write_merge();
  int                e0;
  logic [31:0]       r;
  logic [sb_asz-1:0] item;
  e0 = errors;
  for (int i = 0; i < 12; i++)
  begin
    r    = next_rand();
    item = sb_asz'(7 * int'(r[10:8]));
    if (!model_known[item])
      send_req(req_write, 2'd0, item, 8'hff, r[31:24]);
    send_req(req_write, 2'd0, item, r[7:0], r[23:16]);
    send_req(req_read, r[12:11], item, 8'h00, 8'h00);
    expect_rsp();
  end
  report_test("masked writes", e0);
endtask

task automatic back_to_back_reads();
  int e0;
  e0 = errors;
  fork
    for (int i = 0; i < 4; i++)
      send_req(req_read, sb_txid_sz'(i), sb_asz'(i * 7 + 7), 8'h00, 8'h00);
    repeat (4) expect_rsp();
  join
  report_test("back to back reads", e0);
endtask

task automatic back_pressure_drain();
  int e0;
  int waited;
  e0     = errors;
  waited = 0;
  p_drdy = 1'b0;
  for (int i = 0; i < 5; i++)
    send_req(req_read, sb_txid_sz'(3 - (i % 4)), sb_asz'(i * 7), 8'h00, 8'h00);
  while (c_drdy && waited < max_wait)
  begin
    @(negedge clk);
    waited++;
  end
  assert (c_drdy == 1'b0)
  else
  begin
    $display("ERROR at %0t: c_drdy expected 0, got %0b", $time, c_drdy);
    errors++;
  end
  repeat (5) expect_rsp();
  report_test("back pressure", e0);
endtask

task automatic write_then_read();
  int          e0;
  logic [31:0] r;
  e0 = errors;
  for (int i = 0; i < 4; i++)
  begin
    r = next_rand();
    send_req(req_write, 2'd0, 6'd14, r[7:0], r[15:8]);
    send_req(req_read, sb_txid_sz'(i), 6'd14, 8'h00, 8'h00);  // Next cycle
    expect_rsp();
  end
  report_test("write then read", e0);
endtask

//--- verif/tb_sd_scoreboard.sv
// Scoreboard testbench

`timescale 1ns/10ps

module tb_sd_scoreboard
  import sb_cfg_pkg::*;
  import sb_types_pkg::*;
();

  logic                  clk;
  logic                  rst_n;
  logic                  c_srdy;
  logic                  c_drdy;
  sb_req_e               c_req_type;
  logic [sb_txid_sz-1:0] c_txid;
  logic [sb_asz-1:0]     c_itemid;
  logic [sb_width-1:0]   c_mask;
  logic [sb_width-1:0]   c_data;
  logic                  p_srdy;
  logic                  p_drdy;
  logic [sb_txid_sz-1:0] p_txid;
  logic [sb_width-1:0]   p_data;

  // --------------------
  // Reference model and expected responses
  logic [sb_width-1:0]   model_mem [sb_items];
  logic                  model_known [sb_items];  // Record written at least once
  logic [sb_txid_sz-1:0] exp_txid_q [$];
  logic [sb_width-1:0]   exp_data_q [$];

  logic [31:0] rng_state;
  int          max_wait = 200;  // Cycles per wait loop
  int          errors;
  int          tests_run;
  int          tests_failed;

  always #4 clk = ~clk;

  sd_scoreboard uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .c_srdy     (c_srdy),
    .c_drdy     (c_drdy),
    .c_req_type (c_req_type),
    .c_txid     (c_txid),
    .c_itemid   (c_itemid),
    .c_mask     (c_mask),
    .c_data     (c_data),
    .p_srdy     (p_srdy),
    .p_drdy     (p_drdy),
    .p_txid     (p_txid),
    .p_data     (p_data)
  );

  `include "tb_sd_scoreboard_tasks.svh"

  // --------------------
  // Test sequence
  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    c_srdy       = 1'b0;
    c_req_type   = req_read;
    c_txid       = '0;
    c_itemid     = '0;
    c_mask       = '0;
    c_data       = '0;
    p_drdy       = 1'b0;
    rng_state    = 32'he10d80e8;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < sb_items; i++)
      model_known[i] = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_reset_outputs();
    full_writes_readback();
    masked_write_merge();
    back_to_back_reads();
    back_pressure_drain();
    write_then_read();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule : tb_sd_scoreboard

//--- project.f
+incdir+verif
common/sb_cfg_pkg.sv
common/sb_types_pkg.sv
scoreboard/sd_input.sv
scoreboard/sd_output.sv
scoreboard/behave1p_mem.sv
scoreboard/sd_scoreboard_fsm.sv
scoreboard/sd_scoreboard.sv
verif/tb_sd_scoreboard.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the scoreboard simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tb_sd_scoreboard \
  -o sim_scoreboard &&
./obj_dir/sim_scoreboard | tee /dev/stderr | grep -q "PASS: all tests" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
